// File: Makefile
# Verilator build and run of the branch predictor testbench
OBJ = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -f flist.f --top-module lbpTb -Mdir $(OBJ) -o simv
	./$(OBJ)/simv

clean:
	rm -rf $(OBJ)

// File: dv/lbpTb.sv
/* testbench for the banked local-history predictor; applies a table of
   predicts, updates and flushes and checks every response against a model */
`timescale 1ns/10ps
module lbpTb;
  import lbpPkg::*;

  localparam int numBanks = 4;
  localparam int entriesPerBank = 8;
  localparam int numEntries = numBanks * entriesPerBank;
  localparam int bankW = $clog2(numBanks);
  localparam int idxW = $clog2(entriesPerBank);
  localparam int clkPeriod = 4;
  localparam int resetCycles = 4;
  // hand-written steps first, the rest filled at random
  localparam int numSteps = 240;

  // table operations
  localparam logic [1:0] opIdle = 2'd0;
  localparam logic [1:0] opPred = 2'd1;
  localparam logic [1:0] opUpd = 2'd2;
  localparam logic [1:0] opFlush = 2'd3;

  typedef struct packed {
    logic [1:0] op;
    pc_t        pc;
    logic       taken;
  } step_t;

  logic      clk = 1'b0;
  logic      arstN;
  predReq_t  predReq;
  updReq_t   updReq;
  logic      flush;
  predResp_t predResp;

  step_t     stepTab [numSteps];
  int        fillIdx;
  integer    seed;
  predResp_t expQ [$];

  // model state, indexed by bank * entriesPerBank + entry
  hist_t mCmt [numEntries];
  hist_t mSpec [numEntries];
  logic  mStale [numEntries];
  hist_t lastHist [numEntries];
  ctr_t  mPht [numBanks][2 ** HIST_W];

  always #2 clk = ~clk;

  lbpTop #(
    .numBanks       (numBanks),
    .entriesPerBank (entriesPerBank)
  ) i_lbpTop (
    .clk      (clk),
    .arstN    (arstN),
    .predReq  (predReq),
    .updReq   (updReq),
    .flush    (flush),
    .predResp (predResp)
  );

  //////////////////////////////////////////////////////////////////////
  // behavioral model
  //////////////////////////////////////////////////////////////////////

  function automatic int bankOf(input pc_t pc);
    return int'(pc[2 +: bankW]);
  endfunction

  function automatic int entryOf(input pc_t pc);
    return bankOf(pc) * entriesPerBank + int'(pc[2 + bankW +: idxW]);
  endfunction

  // one step toward the resolved direction, held at both ends
  function automatic ctr_t stepCounter(input ctr_t c, input logic taken);
    if (taken) begin
      return (c == 2'b11) ? c : c + 2'b01;
    end
    return (c == 2'b00) ? c : c - 2'b01;
  endfunction

  task automatic modelReset();
    for (int e = 0; e < numEntries; e++) begin
      mCmt[e] = '0;
      mSpec[e] = '0;
      mStale[e] = 1'b1;
      lastHist[e] = '0;
    end
    for (int b = 0; b < numBanks; b++) begin
      for (int h = 0; h < 2 ** HIST_W; h++) begin
        mPht[b][h] = CTR_RESET;
      end
    end
  endtask

  // stale entries fall back to committed history
  task automatic modelPredict(input pc_t pc, output predResp_t exp);
    int    e;
    hist_t h;
    ctr_t  c;
    e = entryOf(pc);
    h = mStale[e] ? mCmt[e] : mSpec[e];
    c = mPht[bankOf(pc)][h];
    exp = '{valid: 1'b1, taken: c[CTR_W-1], ctr: c, hist: h};
    mSpec[e] = {c[CTR_W-1], h[HIST_W-1:1]};
    mStale[e] = 1'b0;
    lastHist[e] = h;
  endtask

  task automatic modelUpdate(input pc_t pc, input logic taken, input hist_t h);
    int e;
    e = entryOf(pc);
    mCmt[e] = {taken, mCmt[e][HIST_W-1:1]};
    mPht[bankOf(pc)][h] = stepCounter(mPht[bankOf(pc)][h], taken);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus and checking
  //////////////////////////////////////////////////////////////////////

  task automatic putStep(input logic [1:0] op, input pc_t pc, input logic taken);
    stepTab[fillIdx] = '{op: op, pc: pc, taken: taken};
    fillIdx++;
  endtask

  // drive one table step and queue the response it should produce
  task automatic applyStep(input step_t st);
    predResp_t exp;
    hist_t     h;
    exp = '0;
    h = lastHist[entryOf(st.pc)];
    predReq = '0;
    updReq = '0;
    flush = 1'b0;
    case (st.op)
      opPred: begin
        predReq = '{valid: 1'b1, pc: st.pc};
        modelPredict(st.pc, exp);
      end
      opUpd: begin
        updReq = '{valid: 1'b1, pc: st.pc, taken: st.taken, hist: h};
        modelUpdate(st.pc, st.taken, h);
      end
      opFlush: begin
        flush = 1'b1;
        for (int e = 0; e < numEntries; e++) begin
          mStale[e] = 1'b1;
        end
      end
      default: begin
      end
    endcase
    expQ.push_back(exp);
  endtask

  task automatic checkResp(input predResp_t got, input predResp_t exp);
    if (got.valid !== exp.valid) begin
      $display("at %0t a response valid was %b where %b was expected",
               $time, got.valid, exp.valid);
      $display("ERRORS FOUND");
      $fatal(1, "response valid out of step with requests");
    end else if (exp.valid && (got !== exp)) begin
      $display("MISMATCH %0t: taken %b/%b ctr %b/%b hist %b/%b (got/exp)", $time,
               got.taken, exp.taken, got.ctr, exp.ctr, got.hist, exp.hist);
      $display("ERRORS FOUND");
      $fatal(1, "prediction differs from model");
    end
  endtask

  // response for the step driven two falling edges ago
  task automatic checkNext();
    predResp_t exp;
    exp = expQ.pop_front();
    checkResp(predResp, exp);
  endtask

  initial begin
    int r;
    arstN = 1'b0;
    predReq = '0;
    updReq = '0;
    flush = 1'b0;
    fillIdx = 0;
    seed = 32'h65d0;
    modelReset();
    // fresh tables, several banks
    putStep(opPred, 32'h0, 1'b0);
    putStep(opPred, 32'h4, 1'b0);
    putStep(opPred, 32'h28, 1'b0);
    // two taken updates at history 0 saturate the counter
    putStep(opUpd, 32'h4, 1'b1);
    putStep(opUpd, 32'h4, 1'b1);
    putStep(opPred, 32'h4, 1'b0);
    // back-to-back speculation on one entry
    putStep(opPred, 32'h4, 1'b0);
    putStep(opPred, 32'h4, 1'b0);
    putStep(opPred, 32'h4, 1'b0);
    // repair from committed history
    putStep(opFlush, 32'h0, 1'b0);
    putStep(opPred, 32'h4, 1'b0);
    // one predict per cycle across the banks
    for (int i = 0; i < 8; i++) begin
      putStep(opPred, pc_t'(i * 4), 1'b0);
    end
    putStep(opIdle, 32'h0, 1'b0);
    // random mix, pc limited to bank and entry bits
    while (fillIdx < numSteps) begin
      r = $random(seed);
      case (r[2:0])
        3'd4, 3'd5: putStep(opUpd, {25'd0, r[7:3], 2'b00}, r[8]);
        3'd6: putStep(opFlush, 32'h0, 1'b0);
        3'd7: putStep(opIdle, 32'h0, 1'b0);
        default: putStep(opPred, {25'd0, r[7:3], 2'b00}, 1'b0);
      endcase
    end
    // nothing answers in the first two cycles after reset
    expQ.push_back('0);
    expQ.push_back('0);
    repeat (resetCycles) @(negedge clk);
    arstN = 1'b1;
    for (int s = 0; s < numSteps; s++) begin
      @(negedge clk);
      checkNext();
      applyStep(stepTab[s]);
    end
    // drain the two-cycle pipeline
    repeat (2) begin
      @(negedge clk);
      checkNext();
      applyStep('{op: opIdle, pc: '0, taken: 1'b0});
    end
    $display("NO ERRORS");
    $finish;
  end

  // at most four cycles per table step plus reset
  initial begin
    #(numSteps * 4 * clkPeriod + resetCycles * clkPeriod);
    $display("watchdog expired before the table was applied");
    $display("ERRORS FOUND");
    $fatal(1, "timeout");
  end

endmodule

// File: flist.f
rtl/lbpPkg.sv
rtl/lbpDispatch.sv
rtl/lbpBank.sv
rtl/lbpCollect.sv
rtl/lbpTop.sv
dv/lbpTb.sv

// File: rtl/lbpBank.sv
/* one predictor bank with committed and speculative local history tables
   and a pattern table of 2-bit counters; one instance per PC bank */
`timescale 1ns/10ps
module lbpBank #(
  parameter int numBanks = 4,
  parameter int entriesPerBank = 8
) (
  input  logic              clk,
  input  logic              arstN,
  input  lbpPkg::predReq_t  pred,
  input  lbpPkg::updReq_t   upd,
  input  logic              flush,
  output lbpPkg::predResp_t resp
);
  import lbpPkg::*;

  localparam int bankW = $clog2(numBanks);
  localparam int idxW = $clog2(entriesPerBank);
  // one counter per possible history value
  localparam int ctrN = 2 ** HIST_W;

  hist_t                     cmtHist [entriesPerBank];
  hist_t                     specHist [entriesPerBank];
  // set means the speculative entry is not to be trusted
  logic [entriesPerBank-1:0] stale;
  ctr_t                      pht [ctrN];

  logic [idxW-1:0] predIdx;
  logic [idxW-1:0] updIdx;
  hist_t           readHist;
  ctr_t            readCtr;
  logic            readTaken;
  hist_t           nextSpec;
  hist_t           nextCmt;
  ctr_t            updCtr;
  ctr_t            nextCtr;

  logic            respValidQ;
  logic            respTakenQ;
  ctr_t            respCtrQ;
  hist_t           respHistQ;

  //////////////////////////////////////////////////////////////////////
  // prediction read
  //////////////////////////////////////////////////////////////////////

  // index bits right above the bank field
  assign predIdx = pred.pc[2 + bankW +: idxW];
  assign updIdx  = upd.pc[2 + bankW +: idxW];

  // a flush in this cycle already forces the committed copy
  assign readHist  = (stale[predIdx] || flush) ? cmtHist[predIdx] : specHist[predIdx];
  assign readCtr   = pht[readHist];
  assign readTaken = readCtr[CTR_W-1];
  // shift in the predicted direction at the top
  assign nextSpec  = {readTaken, readHist[HIST_W-1:1]};

  //////////////////////////////////////////////////////////////////////
  // committed update
  //////////////////////////////////////////////////////////////////////

  assign nextCmt = {upd.taken, cmtHist[updIdx][HIST_W-1:1]};
  // counter addressed by the history that the prediction used
  assign updCtr  = pht[upd.hist];

  // saturating step toward the resolved direction
  always_comb begin
    nextCtr = updCtr;
    if (upd.taken && (updCtr != 2'b11)) begin
      nextCtr = updCtr + ctr_t'(1);
    end else if (!upd.taken && (updCtr != 2'b00)) begin
      nextCtr = updCtr - ctr_t'(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tables
  //////////////////////////////////////////////////////////////////////

  // history tables, speculative written by predicts, committed by updates
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < entriesPerBank; i++) begin
        cmtHist[i]  <= '0;
        specHist[i] <= '0;
      end
    end else begin
      if (pred.valid) begin
        specHist[predIdx] <= nextSpec;
      end
      if (upd.valid) begin
        cmtHist[updIdx] <= nextCmt;
      end
    end
  end

  // flush marks all stale, a predict in the same cycle revalidates its entry
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      stale <= '1;
    end else begin
      if (flush) begin
        stale <= '1;
      end
      if (pred.valid) begin
        stale[predIdx] <= 1'b0;
      end
    end
  end

  // counters only move on resolved branches
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < ctrN; i++) begin
        pht[i] <= CTR_RESET;
      end
    end else if (upd.valid) begin
      pht[upd.hist] <= nextCtr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      respValidQ <= 1'b0;
    end else begin
      respValidQ <= pred.valid;
    end
  end

  // payload only meaningful with valid
  always_ff @(posedge clk) begin
    respTakenQ <= readTaken;
    respCtrQ   <= readCtr;
    respHistQ  <= readHist;
  end

  assign resp = '{valid: respValidQ, taken: respTakenQ, ctr: respCtrQ, hist: respHistQ};

  // exactly one response per request, one cycle later
  assert property (@(posedge clk) disable iff (!arstN) resp.valid == $past(pred.valid));

endmodule

// File: rtl/lbpCollect.sv
/* output stage; merges the registered bank responses into the single
   prediction stream returned to fetch */
`timescale 1ns/10ps
module lbpCollect #(
  parameter int numBanks = 4
) (
  input  logic              clk,
  input  logic              arstN,
  input  lbpPkg::predResp_t bankResp [numBanks],
  output lbpPkg::predResp_t predResp
);
  import lbpPkg::*;

  logic [numBanks-1:0] respValid;
  predResp_t           merged;

  //////////////////////////////////////////////////////////////////////
  // merge
  //////////////////////////////////////////////////////////////////////

  // idle banks hold old payload, so mask each response by its valid
  always_comb begin
    merged = '0;
    for (int b = 0; b < numBanks; b++) begin
      respValid[b] = bankResp[b].valid;
      if (bankResp[b].valid) begin
        merged = merged | bankResp[b];
      end
    end
  end

  // bank outputs are flops already, so the stream stays registered
  assign predResp = merged;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // the dispatcher sends one predict per cycle, so one bank answers at most
  assert property (@(posedge clk) disable iff (!arstN) $onehot0(respValid));

endmodule

// File: rtl/lbpDispatch.sv
/* input stage of the predictor; registers predict, update and flush and
   steers each request to the bank selected by its PC */
`timescale 1ns/10ps
module lbpDispatch #(
  parameter int numBanks = 4,
  parameter int entriesPerBank = 8
) (
  input  logic              clk,
  input  logic              arstN,
  input  lbpPkg::predReq_t  predReq,
  input  lbpPkg::updReq_t   updReq,
  input  logic              flush,
  output lbpPkg::predReq_t  bankPred [numBanks],
  output lbpPkg::updReq_t   bankUpd [numBanks],
  output logic              bankFlush
);
  import lbpPkg::*;

  // bank field sits right above the 4-byte instruction offset
  localparam int bankW = $clog2(numBanks);
  // entry index lives above the bank field, extracted by the bank
  localparam int idxW = $clog2(entriesPerBank);
  localparam int pcUsed = 2 + bankW + idxW;

  logic                predValidQ;
  pc_t                 predPcQ;
  logic                updValidQ;
  pc_t                 updPcQ;
  logic                updTakenQ;
  hist_t               updHistQ;
  logic                flushQ;
  logic [numBanks-1:0] predSel;
  logic [numBanks-1:0] updSel;

  // control flops
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      predValidQ <= 1'b0;
      updValidQ  <= 1'b0;
      flushQ     <= 1'b0;
    end else begin
      predValidQ <= predReq.valid;
      updValidQ  <= updReq.valid;
      flushQ     <= flush;
    end
  end

  // payload flops, qualified by the valids above
  always_ff @(posedge clk) begin
    predPcQ   <= predReq.pc;
    updPcQ    <= updReq.pc;
    updTakenQ <= updReq.taken;
    updHistQ  <= updReq.hist;
  end

  // one-hot bank decode, pc and payload broadcast to all banks
  always_comb begin
    for (int b = 0; b < numBanks; b++) begin
      predSel[b]  = predValidQ && (predPcQ[2 +: bankW] == bankW'(b));
      updSel[b]   = updValidQ && (updPcQ[2 +: bankW] == bankW'(b));
      bankPred[b] = '{valid: predSel[b], pc: predPcQ};
      bankUpd[b]  = '{valid: updSel[b], pc: updPcQ, taken: updTakenQ, hist: updHistQ};
    end
  end

  // flush reaches every bank in the same cycle
  assign bankFlush = flushQ;

  // a request never lands in two banks, and the index fits the pc
  assert property (@(posedge clk) disable iff (!arstN) $onehot0(predSel) && $onehot0(updSel));
  initial assert (pcUsed <= PC_W);

endmodule

// File: rtl/lbpPkg.sv
/* shared types and widths for the banked local-history branch predictor;
   imported by every RTL module and by the testbench */
package lbpPkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // fetch address width
  localparam int PC_W = 32;
  // local history length, one bit per resolved branch
  localparam int HIST_W = 6;
  // saturating counter width
  localparam int CTR_W = 2;

  typedef logic [PC_W-1:0] pc_t;
  // newest outcome sits in the top bit
  typedef logic [HIST_W-1:0] hist_t;
  // top bit set means predict taken
  typedef logic [CTR_W-1:0] ctr_t;

  // weakly not taken
  localparam ctr_t CTR_RESET = 2'b01;

  //////////////////////////////////////////////////////////////////////
  // request and response streams
  //////////////////////////////////////////////////////////////////////

  // predict request from fetch, 33 bits
  typedef struct packed {
    logic valid;
    pc_t  pc;
  } predReq_t;

  // prediction back to fetch, 10 bits
  typedef struct packed {
    logic  valid;
    logic  taken;
    ctr_t  ctr;
    hist_t hist;
  } predResp_t;

  // resolved branch, carrying the history that the prediction used, 40 bits
  typedef struct packed {
    logic  valid;
    pc_t   pc;
    logic  taken;
    hist_t hist;
  } updReq_t;

endpackage

// File: rtl/lbpTop.sv
/* top level of the banked local-history predictor; dispatcher, one bank
   per PC bank field and the response collector */
`timescale 1ns/10ps
module lbpTop #(
  parameter int numBanks = 4,
  parameter int entriesPerBank = 8
) (
  input  logic              clk,
  input  logic              arstN,
  input  lbpPkg::predReq_t  predReq,
  input  lbpPkg::updReq_t   updReq,
  input  logic              flush,
  output lbpPkg::predResp_t predResp
);
  import lbpPkg::*;

  // per-bank request and response buses
  predReq_t  bankPred [numBanks];
  updReq_t   bankUpd [numBanks];
  predResp_t bankResp [numBanks];
  logic      bankFlush;

  // register inputs and route by bank field
  lbpDispatch #(
    .numBanks       (numBanks),
    .entriesPerBank (entriesPerBank)
  ) i_lbpDispatch (
    .clk       (clk),
    .arstN     (arstN),
    .predReq   (predReq),
    .updReq    (updReq),
    .flush     (flush),
    .bankPred  (bankPred),
    .bankUpd   (bankUpd),
    .bankFlush (bankFlush)
  );

  // identical banks, each owns its slice of the pc space
  for (genvar b = 0; b < numBanks; b++) begin : gBank
    lbpBank #(
      .numBanks       (numBanks),
      .entriesPerBank (entriesPerBank)
    ) i_lbpBank (
      .clk   (clk),
      .arstN (arstN),
      .pred  (bankPred[b]),
      .upd   (bankUpd[b]),
      .flush (bankFlush),
      .resp  (bankResp[b])
    );
  end

  // merge the bank answers
  lbpCollect #(
    .numBanks (numBanks)
  ) i_lbpCollect (
    .clk      (clk),
    .arstN    (arstN),
    .bankResp (bankResp),
    .predResp (predResp)
  );

endmodule
